// ==== hdl/alu_ops_defs.svh ====
`ifndef ALU_OPS_DEFS_SVH
`define ALU_OPS_DEFS_SVH

// --------------------------------------------------
// Packet field widths
// --------------------------------------------------
`define ALU_DATA_W 32
`define ALU_ADDR_W 16
`define ALU_SEQ_W 8
`define ALU_ROUTE_W 4

// Width of the job packet count
`define ALU_COUNT_W 16

// --------------------------------------------------
// Packet FIFO sizing
// --------------------------------------------------
`define ALU_FIFO_DEPTH 16

// Occupancy at which prog_full rises
`define ALU_PROG_THRESH 8

`endif

// ==== hdl/packet_pkg.sv ====
`include "alu_ops_defs.svh"

package packet_pkg;

    // --------------------------------------------------
    // Packet fields
    // --------------------------------------------------

    // Data word of a packet
    typedef logic [`ALU_DATA_W-1:0] packet_data_t;

    // Source address, carried through unchanged
    typedef logic [`ALU_ADDR_W-1:0] packet_addr_t;

    // Sequence tag, carried through unchanged
    typedef logic [`ALU_SEQ_W-1:0] packet_seq_t;

    // Destination route, taken from the configuration
    typedef logic [`ALU_ROUTE_W-1:0] route_t;

endpackage

// ==== hdl/alu_ops_pkg.sv ====
`include "alu_ops_defs.svh"

package alu_ops_pkg;

    // Operation codes, codes 6 and 7 act as pass
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_MUL  = 3'd3,
        ALU_MAX  = 3'd4,
        ALU_MIN  = 3'd5
    } alu_op_t;

    // Packets per job
    typedef logic [`ALU_COUNT_W-1:0] job_count_t;

    // Control FSM states
    typedef enum logic [2:0] {
        IDLE,
        CONFIG_REQ,
        CONFIG_WAIT,
        BUSY,
        PAUSE,
        DRAIN,
        DONE
    } alu_ops_state_t;

endpackage

// ==== hdl/packet_fifo.sv ====
`timescale 1ns/1ps
`include "alu_ops_defs.svh"

module packet_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = `ALU_FIFO_DEPTH,
    parameter int PROG_THRESH = `ALU_PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // Show-ahead, head entry always on dout
    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full)
        else $error("packet_fifo: write while full");

    assert property (@(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty)
        else $error("packet_fifo: read while empty");

endmodule

// ==== hdl/packet_counter.sv ====
`timescale 1ns/1ps

module packet_counter (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    load,
    input  alu_ops_pkg::job_count_t job_count,
    input  logic                    count_en,
    output logic                    count_reached
);

    alu_ops_pkg::job_count_t target;
    alu_ops_pkg::job_count_t tally;

    // Reached flag trails the tally by one cycle
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            target        <= '0;
            tally         <= '0;
            count_reached <= 1'b0;
        end else if (load) begin
            target        <= job_count;
            tally         <= '0;
            count_reached <= 1'b0;
        end else begin
            if (count_en) begin
                tally <= tally + 1'b1;
            end
            count_reached <= (tally == target);
        end
    end

    // No result may land once the job length is met
    assert property (@(posedge ap_clk) disable iff (areset_generator) count_en |-> !count_reached)
        else $error("packet_counter: packet written after count reached");

endmodule

// ==== hdl/alu_ops_fsm.sv ====
`timescale 1ns/1ps

module alu_ops_fsm (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      start_req,
    input  logic                      config_ack,
    input  alu_ops_pkg::alu_op_t      cfg_op,
    input  packet_pkg::packet_data_t  cfg_operand,
    input  packet_pkg::route_t        cfg_route,
    input  logic                      count_reached,
    input  logic                      out_prog_full,
    input  logic                      out_empty,
    output logic                      done_ack,
    output logic                      config_req,
    output logic                      counter_load,
    output logic                      issue_en,
    output alu_ops_pkg::alu_op_t      op,
    output packet_pkg::packet_data_t  operand,
    output packet_pkg::route_t        route
);

    alu_ops_pkg::alu_ops_state_t state;
    alu_ops_pkg::alu_ops_state_t next_state;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= alu_ops_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            alu_ops_pkg::IDLE: begin
                if (start_req) next_state = alu_ops_pkg::CONFIG_REQ;
            end
            alu_ops_pkg::CONFIG_REQ: begin
                if (config_ack) next_state = alu_ops_pkg::CONFIG_WAIT;
            end
            // Wait for the ack to drop before issuing
            alu_ops_pkg::CONFIG_WAIT: begin
                if (!config_ack) next_state = alu_ops_pkg::BUSY;
            end
            alu_ops_pkg::BUSY: begin
                if (count_reached) next_state = alu_ops_pkg::DRAIN;
                else if (out_prog_full) next_state = alu_ops_pkg::PAUSE;
            end
            alu_ops_pkg::PAUSE: begin
                if (count_reached) next_state = alu_ops_pkg::DRAIN;
                else if (!out_prog_full) next_state = alu_ops_pkg::BUSY;
            end
            alu_ops_pkg::DRAIN: begin
                if (out_empty) next_state = alu_ops_pkg::DONE;
            end
            alu_ops_pkg::DONE: begin
                if (!start_req) next_state = alu_ops_pkg::IDLE;
            end
            default: next_state = alu_ops_pkg::IDLE;
        endcase
    end

    assign config_req   = (state == alu_ops_pkg::CONFIG_REQ);
    assign issue_en     = (state == alu_ops_pkg::BUSY);
    assign done_ack     = (state == alu_ops_pkg::DONE);
    assign counter_load = (state == alu_ops_pkg::IDLE) && start_req;

    // Configuration held for the whole job
    always_ff @(posedge ap_clk) begin
        if ((state == alu_ops_pkg::CONFIG_REQ) && config_ack) begin
            op      <= cfg_op;
            operand <= cfg_operand;
            route   <= cfg_route;
        end
    end

    // No late result may land in the output FIFO once the job is done
    assert property (@(posedge ap_clk) disable iff (areset_generator) done_ack |-> out_empty)
        else $error("alu_ops_fsm: output FIFO not empty while done_ack is high");

endmodule

// ==== hdl/alu_ops_datapath.sv ====
`timescale 1ns/1ps

module alu_ops_datapath (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      issue_valid,
    input  alu_ops_pkg::alu_op_t      op,
    input  packet_pkg::packet_data_t  operand,
    input  packet_pkg::route_t        route,
    input  packet_pkg::packet_data_t  src_data,
    input  packet_pkg::packet_addr_t  src_addr,
    input  packet_pkg::packet_seq_t   src_seq,
    output logic                      res_valid,
    output packet_pkg::packet_data_t  res_data,
    output packet_pkg::packet_addr_t  res_addr,
    output packet_pkg::packet_seq_t   res_seq,
    output packet_pkg::route_t        res_route
);

    logic                     s1_valid;
    alu_ops_pkg::alu_op_t     s1_op;
    packet_pkg::packet_data_t s1_data;
    packet_pkg::packet_data_t s1_operand;
    packet_pkg::packet_addr_t s1_addr;
    packet_pkg::packet_seq_t  s1_seq;
    packet_pkg::packet_data_t alu_result;

    // --------------------------------------------------
    // Valid pipe
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            res_valid <= s1_valid;
        end
    end

    // Stage one operand and metadata capture
    always_ff @(posedge ap_clk) begin
        s1_op      <= op;
        s1_data    <= src_data;
        s1_operand <= operand;
        s1_addr    <= src_addr;
        s1_seq     <= src_seq;
    end

    // Unsigned compare for max and min, product truncated to the word
    always_comb begin
        case (s1_op)
            alu_ops_pkg::ALU_ADD: alu_result = s1_data + s1_operand;
            alu_ops_pkg::ALU_SUB: alu_result = s1_data - s1_operand;
            alu_ops_pkg::ALU_MUL: alu_result = s1_data * s1_operand;
            alu_ops_pkg::ALU_MAX: alu_result = (s1_data > s1_operand) ? s1_data : s1_operand;
            alu_ops_pkg::ALU_MIN: alu_result = (s1_data < s1_operand) ? s1_data : s1_operand;
            default:              alu_result = s1_data;
        endcase
    end

    // Stage two result packet
    always_ff @(posedge ap_clk) begin
        res_data  <= alu_result;
        res_addr  <= s1_addr;
        res_seq   <= s1_seq;
        res_route <= route;
    end

endmodule

// ==== hdl/alu_ops_generator.sv ====
`timescale 1ns/1ps

module alu_ops_generator (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      start_req,
    input  alu_ops_pkg::job_count_t   job_count,
    input  logic                      config_ack,
    input  alu_ops_pkg::alu_op_t      cfg_op,
    input  packet_pkg::packet_data_t  cfg_operand,
    input  packet_pkg::route_t        cfg_route,
    input  logic                      in_valid,
    input  packet_pkg::packet_data_t  in_data,
    input  packet_pkg::packet_addr_t  in_addr,
    input  packet_pkg::packet_seq_t   in_seq,
    input  logic                      out_rd_en,
    output logic                      done_ack,
    output logic                      config_req,
    output logic                      in_prog_full,
    output logic                      out_valid,
    output packet_pkg::packet_data_t  out_data,
    output packet_pkg::packet_addr_t  out_addr,
    output packet_pkg::packet_seq_t   out_seq,
    output packet_pkg::route_t        out_route
);

    localparam int IN_W = $bits(packet_pkg::packet_data_t) + $bits(packet_pkg::packet_addr_t)
                        + $bits(packet_pkg::packet_seq_t);
    localparam int OUT_W = IN_W + $bits(packet_pkg::route_t);

    logic [IN_W-1:0]          in_dout;
    logic                     in_empty;
    logic                     in_pop;
    logic                     out_empty;
    logic                     out_prog_full;
    logic                     issue_en;
    logic                     counter_load;
    logic                     count_reached;
    alu_ops_pkg::alu_op_t     op;
    packet_pkg::packet_data_t operand;
    packet_pkg::route_t       route;
    logic                     res_valid;
    packet_pkg::packet_data_t res_data;
    packet_pkg::packet_addr_t res_addr;
    packet_pkg::packet_seq_t  res_seq;
    packet_pkg::route_t       res_route;
    packet_pkg::packet_data_t src_data;
    packet_pkg::packet_addr_t src_addr;
    packet_pkg::packet_seq_t  src_seq;

    // --------------------------------------------------
    // Input buffer
    // --------------------------------------------------
    assign in_pop = issue_en & ~in_empty;
    assign {src_data, src_addr, src_seq} = in_dout;

    packet_fifo #(.WIDTH(IN_W)) in_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (in_valid),
        .din              ({in_data, in_addr, in_seq}),
        .rd_en            (in_pop),
        .dout             (in_dout),
        .empty            (in_empty),
        .full             (),
        .prog_full        (in_prog_full)
    );

    alu_ops_fsm fsm_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start_req        (start_req),
        .config_ack       (config_ack),
        .cfg_op           (cfg_op),
        .cfg_operand      (cfg_operand),
        .cfg_route        (cfg_route),
        .count_reached    (count_reached),
        .out_prog_full    (out_prog_full),
        .out_empty        (out_empty),
        .done_ack         (done_ack),
        .config_req       (config_req),
        .counter_load     (counter_load),
        .issue_en         (issue_en),
        .op               (op),
        .operand          (operand),
        .route            (route)
    );

    // Tally counts results as they enter the output FIFO
    packet_counter counter_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .job_count        (job_count),
        .count_en         (res_valid),
        .count_reached    (count_reached)
    );

    alu_ops_datapath datapath_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .issue_valid      (in_pop),
        .op               (op),
        .operand          (operand),
        .route            (route),
        .src_data         (src_data),
        .src_addr         (src_addr),
        .src_seq          (src_seq),
        .res_valid        (res_valid),
        .res_data         (res_data),
        .res_addr         (res_addr),
        .res_seq          (res_seq),
        .res_route        (res_route)
    );

    // --------------------------------------------------
    // Output buffer
    // --------------------------------------------------
    assign out_valid = ~out_empty;

    packet_fifo #(.WIDTH(OUT_W)) out_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (res_valid),
        .din              ({res_data, res_addr, res_seq, res_route}),
        .rd_en            (out_rd_en & out_valid),
        .dout             ({out_data, out_addr, out_seq, out_route}),
        .empty            (out_empty),
        .full             (),
        .prog_full        (out_prog_full)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic ap_clk,
    output logic areset_generator
);

    initial begin
        ap_clk = 1'b0;
        forever #(HALF_PERIOD) ap_clk = ~ap_clk;
    end

    // Reset released on a rising edge
    initial begin
        areset_generator = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_generator <= 1'b0;
    end

endmodule

// ==== sim/alu_ops_checker.sv ====
`timescale 1ns/1ps

module alu_ops_checker (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     start_req,
    input  alu_ops_pkg::job_count_t  job_count,
    input  logic                     config_req,
    input  logic                     config_ack,
    input  logic                     done_ack,
    input  alu_ops_pkg::alu_op_t     cfg_op,
    input  packet_pkg::packet_data_t cfg_operand,
    input  packet_pkg::route_t       cfg_route,
    input  logic                     in_valid,
    input  packet_pkg::packet_data_t in_data,
    input  packet_pkg::packet_addr_t in_addr,
    input  packet_pkg::packet_seq_t  in_seq,
    input  logic                     in_prog_full,
    input  logic                     out_valid,
    input  logic                     out_rd_en,
    input  packet_pkg::packet_data_t out_data,
    input  packet_pkg::packet_addr_t out_addr,
    input  packet_pkg::packet_seq_t  out_seq,
    input  packet_pkg::route_t       out_route,
    output int                       error_count
);

    typedef struct packed {
        packet_pkg::packet_data_t data;
        packet_pkg::packet_addr_t addr;
        packet_pkg::packet_seq_t  seq;
        packet_pkg::route_t       route;
    } result_pkt_t;

    result_pkt_t              expected_q[$];
    alu_ops_pkg::alu_op_t     cur_op;
    packet_pkg::packet_data_t cur_operand;
    packet_pkg::route_t       cur_route;
    alu_ops_pkg::job_count_t  job_target;
    int                       popped = 0;
    int                       errors = 0;
    logic                     reset_checked = 1'b0;
    logic                     start_q = 1'b0;
    logic                     config_req_q = 1'b0;
    logic                     done_q = 1'b0;

    assign error_count = errors;

    // Reference ALU with the 64-bit product cut to its low word
    function automatic packet_pkg::packet_data_t expected_result(
        input alu_ops_pkg::alu_op_t     op_code,
        input packet_pkg::packet_data_t a,
        input packet_pkg::packet_data_t b
    );
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        if (op_code == alu_ops_pkg::ALU_ADD) return a + b;
        if (op_code == alu_ops_pkg::ALU_SUB) return a - b;
        if (op_code == alu_ops_pkg::ALU_MUL) return product[31:0];
        if (op_code == alu_ops_pkg::ALU_MAX) return (a >= b) ? a : b;
        if (op_code == alu_ops_pkg::ALU_MIN) return (a <= b) ? a : b;
        return a;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    // --------------------------------------------------
    // Sampled on each rising edge before the DUT updates
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        result_pkt_t sent_pkt;
        result_pkt_t want;
        if (!areset_generator) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (done_ack || config_req || out_valid || in_prog_full) begin
                    report_error("done_ack, config_req, out_valid or in_prog_full "
                                 + "not low after reset");
                end
            end
            if (start_req && !start_q) begin
                job_target = job_count;
                popped = 0;
            end
            if (config_req && !config_req_q && !start_req) begin
                report_error("config_req rose without start_req");
            end
            if (!config_req && config_req_q && !config_ack) begin
                report_error("config_req fell before config_ack");
            end
            // Configuration taken on the first cycle of the ack
            if (config_req && config_ack) begin
                cur_op      = cfg_op;
                cur_operand = cfg_operand;
                cur_route   = cfg_route;
            end
            if (in_valid) begin
                sent_pkt.data  = expected_result(cur_op, in_data, cur_operand);
                sent_pkt.addr  = in_addr;
                sent_pkt.seq   = in_seq;
                sent_pkt.route = cur_route;
                expected_q.push_back(sent_pkt);
            end
            if (out_valid && out_rd_en) begin
                popped++;
                if (expected_q.size() == 0) begin
                    report_error("output packet popped with no input packet pending");
                end else begin
                    want = expected_q.pop_front();
                    compare_field("out_data", out_data, want.data);
                    compare_field("out_addr", 32'(out_addr), 32'(want.addr));
                    compare_field("out_seq", 32'(out_seq), 32'(want.seq));
                    compare_field("out_route", 32'(out_route), 32'(want.route));
                end
            end
            if (done_ack && !done_q) begin
                compare_field("packet_count", popped, 32'(job_target));
                if (expected_q.size() != 0) begin
                    report_error("done_ack rose with packets still outstanding");
                end
            end
            if (!done_ack && done_q && start_req) begin
                report_error("done_ack fell while start_req was still high");
            end
            if (done_ack && out_valid) begin
                report_error("out_valid high while done_ack is high");
            end
            start_q      = start_req;
            config_req_q = config_req;
            done_q       = done_ack;
        end
    end

endmodule

// ==== sim/alu_ops_generator_tb.sv ====
`timescale 1ns/1ps

module alu_ops_generator_tb;

    localparam int NUM_JOBS       = 7;
    localparam int WAIT_LIMIT     = 2000;
    localparam int HOLD_LIMIT     = 80;
    localparam int SIG_RESET      = 0;
    localparam int SIG_CONFIG_REQ = 1;
    localparam int SIG_DONE_ACK   = 2;

    typedef struct packed {
        alu_ops_pkg::alu_op_t     op;
        packet_pkg::packet_data_t operand;
        packet_pkg::route_t       route;
        alu_ops_pkg::job_count_t  count;
        logic                     back_pressure;
    } job_row_t;

    logic                     ap_clk;
    logic                     areset_generator;
    logic                     start_req = 1'b0;
    alu_ops_pkg::job_count_t  job_count = '0;
    logic                     config_ack = 1'b0;
    alu_ops_pkg::alu_op_t     cfg_op = alu_ops_pkg::ALU_PASS;
    packet_pkg::packet_data_t cfg_operand = '0;
    packet_pkg::route_t       cfg_route = '0;
    logic                     in_valid = 1'b0;
    packet_pkg::packet_data_t in_data = '0;
    packet_pkg::packet_addr_t in_addr = '0;
    packet_pkg::packet_seq_t  in_seq = '0;
    logic                     out_rd_en = 1'b0;
    logic                     done_ack;
    logic                     config_req;
    logic                     in_prog_full;
    logic                     out_valid;
    packet_pkg::packet_data_t out_data;
    packet_pkg::packet_addr_t out_addr;
    packet_pkg::packet_seq_t  out_seq;
    packet_pkg::route_t       out_route;
    int                       error_count;

    job_row_t    jobs [NUM_JOBS];
    logic [15:0] lfsr = 16'd35;
    logic        hold_reads = 1'b0;
    int          hold_cycles = 0;
    int          timeouts = 0;

    tb_clock_gen clock_gen_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator)
    );

    alu_ops_generator alu_ops_generator_i (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .start_req (start_req), .job_count (job_count), .config_ack (config_ack),
        .cfg_op (cfg_op), .cfg_operand (cfg_operand), .cfg_route (cfg_route),
        .in_valid (in_valid), .in_data (in_data), .in_addr (in_addr), .in_seq (in_seq),
        .out_rd_en (out_rd_en), .done_ack (done_ack), .config_req (config_req),
        .in_prog_full (in_prog_full), .out_valid (out_valid), .out_data (out_data),
        .out_addr (out_addr), .out_seq (out_seq), .out_route (out_route)
    );

    alu_ops_checker checker_i (
        .ap_clk (ap_clk), .areset_generator (areset_generator),
        .start_req (start_req), .job_count (job_count), .config_req (config_req),
        .config_ack (config_ack), .done_ack (done_ack), .cfg_op (cfg_op),
        .cfg_operand (cfg_operand), .cfg_route (cfg_route), .in_valid (in_valid),
        .in_data (in_data), .in_addr (in_addr), .in_seq (in_seq),
        .in_prog_full (in_prog_full),
        .out_valid (out_valid), .out_rd_en (out_rd_en), .out_data (out_data),
        .out_addr (out_addr), .out_seq (out_seq), .out_route (out_route),
        .error_count (error_count)
    );

    // Columns are op, operand, route, packet count and back-pressure
    task automatic load_job_table();
        jobs[0] = '{alu_ops_pkg::ALU_ADD,  32'h0000_1000, 4'h3, 16'd12, 1'b0};
        jobs[1] = '{alu_ops_pkg::ALU_SUB,  32'h0000_00ff, 4'h5, 16'd10, 1'b0};
        jobs[2] = '{alu_ops_pkg::ALU_MUL,  32'h0000_0007, 4'h9, 16'd24, 1'b1};
        jobs[3] = '{alu_ops_pkg::ALU_MAX,  32'h8000_0000, 4'ha, 16'd9,  1'b0};
        jobs[4] = '{alu_ops_pkg::ALU_MIN,  32'h7000_0000, 4'hc, 16'd20, 1'b1};
        jobs[5] = '{alu_ops_pkg::ALU_PASS, 32'hdead_beef, 4'h1, 16'd6,  1'b0};
        jobs[6] = '{alu_ops_pkg::ALU_ADD,  32'hffff_ffff, 4'hf, 16'd16, 1'b0};
    endtask

    // --------------------------------------------------
    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic sample_signal(input int sel);
        case (sel)
            SIG_RESET:      return areset_generator;
            SIG_CONFIG_REQ: return config_req;
            default:        return done_ack;
        endcase
    endfunction

    // One clock edge with the output reader driven on it
    task automatic next_cycle();
        logic [31:0] bits;
        @(posedge ap_clk);
        if (hold_reads) begin
            hold_cycles++;
            if (in_prog_full || hold_cycles >= HOLD_LIMIT) hold_reads = 1'b0;
        end
        if (hold_reads) begin
            out_rd_en <= 1'b0;
        end else begin
            take_bits(2, bits);
            out_rd_en <= (bits[1:0] != 2'b00);
        end
    endtask

    task automatic wait_signal(input int sel, input logic level, input string name);
        int n;
        n = 0;
        while (sample_signal(sel) !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (sample_signal(sel) !== level) begin
            timeouts++;
            $display("Timeout: %s did not go to %0d within %0d cycles", name, level, n);
        end
    endtask

    task automatic run_job(input job_row_t row, input int job_idx);
        int          sent;
        int          idle;
        logic [31:0] bits;
        logic [31:0] word;
        next_cycle();
        job_count   <= row.count;
        start_req   <= 1'b1;
        hold_reads  = row.back_pressure;
        hold_cycles = 0;
        wait_signal(SIG_CONFIG_REQ, 1'b1, "config_req");
        if (timeouts != 0) return;
        cfg_op      <= row.op;
        cfg_operand <= row.operand;
        cfg_route   <= row.route;
        config_ack  <= 1'b1;
        wait_signal(SIG_CONFIG_REQ, 1'b0, "config_req");
        if (timeouts != 0) return;
        config_ack <= 1'b0;
        sent = 0;
        idle = 0;
        while (sent < int'(row.count) && timeouts == 0) begin
            next_cycle();
            take_bits(2, bits);
            if (!in_prog_full && bits[1:0] != 2'b00) begin
                take_bits(32, word);
                in_valid <= 1'b1;
                in_data  <= word;
                in_addr  <= packet_pkg::packet_addr_t'(job_idx * 256 + sent);
                in_seq   <= packet_pkg::packet_seq_t'(sent);
                sent++;
                idle = 0;
            end else begin
                in_valid <= 1'b0;
                idle++;
                if (idle >= WAIT_LIMIT) begin
                    timeouts++;
                    $display("Timeout: input FIFO never dropped below its threshold");
                end
            end
        end
        next_cycle();
        in_valid <= 1'b0;
        wait_signal(SIG_DONE_ACK, 1'b1, "done_ack");
        if (timeouts != 0) return;
        start_req <= 1'b0;
        wait_signal(SIG_DONE_ACK, 1'b0, "done_ack");
    endtask

    initial begin
        load_job_table();
        wait_signal(SIG_RESET, 1'b0, "areset_generator");
        for (int row = 0; row < NUM_JOBS; row++) begin
            if (timeouts == 0) run_job(jobs[row], row);
        end
        for (int i = 0; i < 4; i++) begin
            next_cycle();
        end
        $display("Run complete: %0d errors, %0d timeouts", error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/packet_pkg.sv
hdl/alu_ops_pkg.sv
hdl/packet_fifo.sv
hdl/packet_counter.sv
hdl/alu_ops_fsm.sv
hdl/alu_ops_datapath.sv
hdl/alu_ops_generator.sv
sim/tb_clock_gen.sv
sim/alu_ops_checker.sv
sim/alu_ops_generator_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_ops_generator_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
